//--- flist.f
verilog/fetchPkg.sv
verilog/fetchIf.sv
verilog/pcSequencer.sv
verilog/icacheTile.sv
verilog/instrLengthDecoder.sv
verilog/fetchTop.sv
tests/tbMemory.sv
tests/fetchTb.sv

//--- Makefile
TOP = fetchTb

all: run

build:
	verilator --binary --timing -Wno-fatal -j 0 -f flist.f --top-module $(TOP) -o simFetch

run: build
	@out="$$(./obj_dir/simFetch)"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- tests/fetchTb.sv
`timescale 1ns/1ps

module fetchTb
	import fetchPkg::*;
();

	localparam logic [31:0] startPc = 32'h0000_0a36;	// mid-line halfword
	localparam int targetCount = 2000;
	localparam int watchdogNs = targetCount * (5 + 6) * 100 + 8 * 100;

	logic                   clock;
	logic                   rst;
	logic                   branchStrobe;
	logic [31:0]            branchPc;
	logic [blockBits-1:0]   memData;
	memOk_t                 memStatus;
	logic [memAddrBits-1:0] memAddr;
	logic                   memOe;
	logic                   instrValid;
	logic [31:0]            instr;
	instrKind_t             instrWide;
	logic [31:0]            instrPc;

	logic [31:0]            modelPc = startPc;	// next PC expected to issue
	logic [31:0]            target;	// redirect target not yet applied
	logic [31:0]            awaitPc;	// first PC expected after a redirect
	logic                   redirectPending = 1'b0;
	logic                   awaitValid = 1'b0;
	logic                   redirectSinceReq = 1'b0;
	logic                   firstReq = 1'b1;
	logic                   lastOe = 1'b0;
	logic [memAddrBits-1:0] lastReq;
	int                     issued = 0;
	int                     edgeCount = 0;
	int                     redirects = 0;
	int                     fails [6] = '{default: 0};
	string                  names [6] = '{"reset state", "sequential stream",
		"line and block edges", "redirect", "fill protocol", "progress"};

	fetchTop #(
		.resetPc (startPc)
	) u_fetchTop (
		.memOk   (memStatus),
		.*
	);

	tbMemory u_tbMemory (.*);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial
	begin
		#(watchdogNs);
		$display("timeout, only %0d of %0d instructions issued", issued, targetCount);
		$display("SIMULATION FAILED");
		$finish;
	end

	task automatic reportMismatch(input int id, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Fail %s expected %h actual %h", names[id], expected, actual);
		fails[id]++;
	endtask

	task automatic reportProblem(input int id, input string what);
		$display("%s: %s", names[id], what);
		fails[id]++;
	endtask

	// a new request must be for the line the model is waiting on
	task automatic checkFill();
		logic [memAddrBits-1:0] expAddr;
		expAddr = {modelPc[memAddrBits-1:4], 4'b0000};
		if (memOe && !lastOe)
		begin
			if (memAddr !== expAddr)
				reportMismatch(firstReq ? 0 : 4, 32'(expAddr), 32'(memAddr));
			if (!firstReq && memAddr == lastReq && !redirectSinceReq)
				reportProblem(4, "same line requested twice without a redirect");
			if (firstReq)
				$display("test %s finished with %0d failures", names[0], fails[0]);
			firstReq = 1'b0;
			lastReq = memAddr;
			redirectSinceReq = 1'b0;
		end
		else if (memOe && memAddr !== lastReq)
			reportProblem(4, "memAddr changed while the request was pending");
		lastOe = memOe;
	endtask

	task automatic checkIssue();
		logic [15:0] lo;
		logic [15:0] hi;
		logic [31:0] expInstr;
		instrKind_t  expKind;
		int          id;
		lo = u_tbMemory.image[modelPc[11:1]];
		hi = u_tbMemory.image[modelPc[11:1] + 11'd1];
		expKind = (lo[15:13] == 3'b111) ? kindWide : kindShort;
		expInstr = (expKind == kindWide) ? {hi, lo} : {16'h0000, lo};
		id = (modelPc[3:1] == 3'b111) ? 2 : 1;	// last halfword of a line
		if (instrPc !== modelPc)
			reportMismatch(id, modelPc, instrPc);
		if (instr !== expInstr)
			reportMismatch(id, expInstr, instr);
		if (instrWide !== expKind)
			reportMismatch(id, 32'(expKind), 32'(instrWide));
		if (awaitValid)
		begin
			if (instrPc !== awaitPc)
				reportMismatch(3, awaitPc, instrPc);
			redirects++;
			awaitValid = 1'b0;
		end
		if (id == 2)
			edgeCount++;
		modelPc = modelPc + ((expKind == kindWide) ? 32'd4 : 32'd2);
		issued++;
	endtask

	initial
	begin
		int seedVal;
		int total;
		seedVal = $urandom(86031);
		rst = 1'b1;
		branchStrobe = 1'b0;
		branchPc = '0;
		repeat (8)
		begin
			@(negedge clock);
			if (instrValid !== 1'b0 || memOe !== 1'b0)
				reportProblem(0, "instrValid or memOe high during reset");
		end
		rst = 1'b0;
		while (issued < targetCount)
		begin
			@(negedge clock);
			checkFill();
			if (instrValid)
				checkIssue();	// fetched before any redirect of last cycle
			if (redirectPending)
			begin
				modelPc = target;
				awaitPc = target;
				awaitValid = 1'b1;
				redirectPending = 1'b0;
			end
			branchStrobe = 1'b0;
			if (($urandom % 40) == 0)
			begin
				target = {20'd0, 11'($urandom), 1'b0};	// any halfword of the image
				branchPc = target;
				branchStrobe = 1'b1;
				redirectPending = 1'b1;
				redirectSinceReq = 1'b1;
			end
		end
		branchStrobe = 1'b0;
		if (edgeCount == 0)
			reportProblem(2, "no instruction came from the last halfword of a line");
		for (int i = 1; i < 6; i++)
			$display("test %s finished with %0d failures", names[i], fails[i]);
		total = 0;
		foreach (fails[i])
			total += fails[i];
		$display("%0d failures, %0d issued, %0d at line edges, %0d redirects checked",
			total, issued, edgeCount, redirects);
		if (total == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- tests/tbMemory.sv
`timescale 1ns/1ps

module tbMemory
	import fetchPkg::*;
(
	input  logic                   clock,
	input  logic                   rst,
	input  logic [memAddrBits-1:0] memAddr,
	input  logic                   memOe,
	output logic [blockBits-1:0]   memData,
	output memOk_t                 memStatus
);

	logic [15:0] image [0:2047];	// 4 KB, one entry per halfword
	logic        imageReady = 1'b0;
	int          holdLeft = -1;	// hold cycles still to show, -1 when idle
	logic [15:0] hw;
	logic [10:0] idx;

	initial
	begin
		memData = '0;
		memStatus = memReady;
	end

	always @(negedge clock)
	begin
		if (rst && !imageReady)
		begin
			// random halfwords, about a third carry the wide pattern
			for (int i = 0; i < 2048; i++)
			begin
				hw = 16'($urandom);
				if (($urandom % 3) == 0)
					hw[15:13] = 3'b111;
				else if (hw[15:13] == 3'b111)
					hw[15] = 1'b0;
				image[11'(i)] = hw;
			end
			imageReady = 1'b1;
		end
		if (rst || memStatus == memOk)
		begin
			memStatus = memReady;	// one reply per request
			holdLeft = -1;
		end
		else if (memOe)
		begin
			if (holdLeft < 0)
				holdLeft = int'($urandom_range(5, 1));
			if (holdLeft == 0)
			begin
				// shift in from the top, lowest halfword ends at bit 0
				for (int h = 0; h < 16; h++)
				begin
					idx = memAddr[11:1] + 11'(h);	// wraps inside the image
					memData = {image[idx], memData[blockBits-1:16]};
				end
				memStatus = memOk;
			end
			else
			begin
				holdLeft = holdLeft - 1;
				memStatus = memHold;
			end
		end
	end

endmodule

//--- verilog/fetchTop.sv
`timescale 1ns/1ps

module fetchTop
	import fetchPkg::*;
#(
	parameter logic [31:0] resetPc = 32'h0000_0100	// must be halfword aligned
) (
	input  logic                   clock,
	input  logic                   rst,

	// branch redirect
	input  logic                   branchStrobe,
	input  logic [31:0]            branchPc,

	// memory side
	input  logic [blockBits-1:0]   memData,
	input  memOk_t                 memOk,
	output logic [memAddrBits-1:0] memAddr,
	output logic                   memOe,

	// issue side
	output logic                   instrValid,
	output logic [31:0]            instr,
	output instrKind_t             instrWide,
	output logic [31:0]            instrPc
);

	fetchIf fetch();	// PC, window, status and step between the blocks

	pcSequencer #(
		.resetPc      (resetPc)
	) u_pcSequencer (
		.clock        (clock),
		.rst          (rst),
		.branchStrobe (branchStrobe),
		.branchPc     (branchPc),
		.fetch        (fetch.seqPort)
	);

	icacheTile u_icacheTile (
		.clock        (clock),
		.rst          (rst),
		.fetch        (fetch.cachePort),
		.memData      (memData),
		.memOk        (memOk),
		.memAddr      (memAddr),
		.memOe        (memOe)
	);

	instrLengthDecoder u_instrLengthDecoder (
		.clock        (clock),
		.rst          (rst),
		.fetch        (fetch.decodePort),
		.instrValid   (instrValid),
		.instr        (instr),
		.instrWide    (instrWide),
		.instrPc      (instrPc)
	);

endmodule

//--- verilog/instrLengthDecoder.sv
`timescale 1ns/1ps

module instrLengthDecoder
	import fetchPkg::*;
(
	input  logic        clock,
	input  logic        rst,
	fetchIf.decodePort  fetch,

	output logic        instrValid,	// one cycle per issued instruction
	output logic [31:0] instr,	// short ones are zero-extended
	output instrKind_t  instrWide,
	output logic [31:0] instrPc	// address of the issued instruction
);

	instrKind_t  kind;	// size of the instruction in the window
	logic        fire;	// window is valid this cycle
	logic [31:0] issueData;

	assign fire = (fetch.status == memOk);

	// top three bits of the first halfword all set marks a wide one
	always_comb
	begin
		if (fetch.window[15:13] == 3'b111)
			kind = kindWide;
		else
			kind = kindShort;
	end

	always_comb
	begin
		if (kind == kindWide)
			issueData = fetch.window;
		else
			issueData = {16'h0000, fetch.window[15:0]};
	end

	// advance only when the window was actually consumed
	always_comb
	begin
		if (!fire)
			fetch.step = 3'd0;
		else if (kind == kindWide)
			fetch.step = 3'd4;
		else
			fetch.step = 3'd2;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			instrValid <= 1'b0;
		else
			instrValid <= fire;
	end

	// issue registers, loaded on every consumed window
	always_ff @(posedge clock)
	begin
		if (fire)
		begin
			instr     <= issueData;
			instrWide <= kind;
			instrPc   <= fetch.pc;	// PC of the fetch cycle
		end
	end

endmodule

//--- verilog/icacheTile.sv
`timescale 1ns/1ps

module icacheTile
	import fetchPkg::*;
(
	input  logic                   clock,
	input  logic                   rst,
	fetchIf.cachePort              fetch,

	input  logic [blockBits-1:0]   memData,	// two lines, low line in low half
	input  memOk_t                 memOk,	// memory status
	output logic [memAddrBits-1:0] memAddr,	// line address of the request
	output logic                   memOe	// request pending
);

	localparam int offBits = $clog2(lineBytes);	// byte offset within a line
	localparam int lineNumBits = memAddrBits - offBits;	// line number width
	localparam int hwIndexBits = $clog2(blockBits / 16);	// halfword slot in block

	// fill sequencer
	typedef enum logic
	{
		fillIdle,	// no request out
		fillWait	// request out, waiting for memOk
	} fillState_t;

	fillState_t fillState;

	logic [blockBits-1:0]   blkData;	// cached block
	logic [lineNumBits-1:0] blkLine;	// line number of the lower line
	logic                   blkFilled;	// block holds valid data
	logic [lineNumBits-1:0] reqLine;	// line being fetched

	logic [lineNumBits-1:0] pcLine;	// line of the fetch PC
	logic [lineNumBits-1:0] blkNextLine;	// line of the upper half
	logic                   inLowLine;
	logic                   inHighLine;
	logic                   lastHalf;	// PC on the final halfword of its line
	logic                   pcHit;
	logic [hwIndexBits-1:0] hwIndex;	// halfword slot of the PC
	logic [blockBits-1:0]   shiftedBlk;

	logic                   startReq;
	logic                   memDone;

	assign pcLine      = fetch.pc[memAddrBits-1:offBits];
	assign blkNextLine = blkLine + 1'b1;	// wraps like the memory does
	assign lastHalf    = &fetch.pc[offBits-1:1];

	assign inLowLine  = (pcLine == blkLine);
	assign inHighLine = (pcLine == blkNextLine);

	// The last halfword of the upper line would need bits beyond the
	// block, so it counts as a miss. The refill then starts at that line
	// and the whole 32-bit window is present afterwards.
	assign pcHit = blkFilled && (inLowLine || (inHighLine && !lastHalf));

	// window select, shift the block down by the halfword slot
	assign hwIndex    = {inHighLine, fetch.pc[offBits-1:1]};
	assign shiftedBlk = blkData >> {hwIndex, 4'b0000};

	assign fetch.window = shiftedBlk[31:0];
	assign fetch.status = pcHit ? fetchPkg::memOk : memHold;

	assign startReq = (fillState == fillIdle) && !pcHit;
	assign memDone  = (fillState == fillWait) && (memOk == fetchPkg::memOk);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			fillState <= fillIdle;
			blkFilled <= 1'b0;
		end
		else
		begin
			case (fillState)
				fillIdle:
				begin
					if (startReq)
					begin
						fillState <= fillWait;
						blkFilled <= 1'b0;	// nothing hits while the fill runs
					end
				end
				fillWait:
				begin
					if (memDone)
					begin
						fillState <= fillIdle;
						blkFilled <= 1'b1;
					end
				end
				default:
					fillState <= fillIdle;
			endcase
		end
	end

	// Request line and block contents. The request line is captured once,
	// so a redirect during the fill leaves the address on the bus alone.
	// The new PC is looked up again once the block is in.
	always_ff @(posedge clock)
	begin
		if (startReq)
			reqLine <= pcLine;
		if (memDone)
		begin
			blkData <= memData;
			blkLine <= reqLine;
		end
	end

	assign memAddr = {reqLine, {offBits{1'b0}}};	// line aligned
	assign memOe   = (fillState == fillWait);	// held until memOk

endmodule

//--- verilog/pcSequencer.sv
`timescale 1ns/1ps

module pcSequencer #(
	parameter logic [31:0] resetPc = 32'h0000_0100	// fetch address after reset
) (
	input  logic        clock,
	input  logic        rst,
	input  logic        branchStrobe,	// one-cycle redirect request
	input  logic [31:0] branchPc,	// redirect target
	fetchIf.seqPort     fetch
);

	logic [31:0] pcReg;	// architectural fetch PC
	logic [31:0] targetPc;	// branch target, forced to a halfword
	logic [31:0] stepPc;	// sequential successor
	logic [31:0] nextPc;

	// redirect targets are halfword aligned, bit 0 is dropped
	assign targetPc = {branchPc[31:1], 1'b0};

	// step is zero while the cache holds, so the PC simply stays
	assign stepPc = pcReg + {29'd0, fetch.step};

	// A redirect wins over the step. The instruction fetched in the
	// strobe cycle is still registered by the decoder at the same edge,
	// so nothing is lost by overwriting the PC here.
	always_comb
	begin
		if (branchStrobe)
			nextPc = targetPc;
		else
			nextPc = stepPc;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			pcReg <= resetPc;
		else
			pcReg <= nextPc;
	end

	assign fetch.pc = pcReg;

endmodule

//--- verilog/fetchIf.sv
`timescale 1ns/1ps

interface fetchIf
	import fetchPkg::*;
();

	logic [31:0] pc;	// current fetch address
	logic [31:0] window;	// 32 bits starting at pc
	memOk_t      status;	// ok on a hit, hold while the line is missing
	logic [2:0]  step;	// bytes to advance, 0/2/4

	// holds the PC and follows the step
	modport seqPort
	(
		output pc,
		input  step
	);

	// looks up the PC and serves the window
	modport cachePort
	(
		input  pc,
		output window,
		output status
	);

	// sizes the window and reports the step
	modport decodePort
	(
		input  pc,
		input  window,
		input  status,
		output step
	);

endinterface

//--- verilog/fetchPkg.sv
package fetchPkg;

	// memory and fetch status, same encoding as the memory bus
	typedef enum logic [1:0]
	{
		memReady = 2'b00,	// idle, nothing in flight
		memOk    = 2'b01,	// data valid this cycle
		memHold  = 2'b10,	// busy, requester keeps its address
		memFault = 2'b11	// reserved for a bus error
	} memOk_t;

	// instruction size as seen by the length decoder
	typedef enum logic
	{
		kindShort = 1'b0,	// 16-bit instruction
		kindWide  = 1'b1	// 32-bit instruction
	} instrKind_t;

	// block geometry
	// one cached block is two consecutive lines

	localparam int blockBits = 256;	// bits per cached block

	localparam int lineBytes = 16;	// bytes per line

	localparam int memAddrBits = 20;	// memory byte address width

endpackage
